// File: hdl/render_pkg.sv
package render_pkg;

	//////////////////////////////////////////////////
	// display geometry
	//////////////////////////////////////////////////

	// screen coordinate, 10 bits covers 640 x 480
	typedef logic [9:0] coord_t;

	localparam int DISPLAY_W = 640;
	localparam int DISPLAY_H = 480;

	// scenery bands, row counts in sprite units (times SCALE)
	localparam int HILLS_Y = 300;
	localparam int HILLS_ROWS = 40;
	localparam int FLOOR_ROWS = 10;

	// pipe body size in sprite units
	localparam int PIPE_COLS = 26;
	localparam int PIPE_ROWS = 120;

	// one floor stripe, sprite units
	localparam int STRIPE_COLS = 8;

	//////////////////////////////////////////////////
	// game state, one-hot
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		st_start = 4'b0001,
		st_play  = 4'b0010,
		st_pause = 4'b0100,
		st_over  = 4'b1000
	} game_state_t;

	//////////////////////////////////////////////////
	// colours
	//////////////////////////////////////////////////

	// channel view, r in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_ch_t;

	typedef union packed {
		logic [23:0] word;
		rgb_ch_t     ch;
	} rgb_t;

	localparam logic [23:0] COL_NONE    = 24'h000000;
	localparam logic [23:0] COL_SKY     = 24'h70C5CE;
	localparam logic [23:0] COL_HILLS   = 24'h5EC45A;
	localparam logic [23:0] COL_FLOOR_A = 24'h9BE15D;
	localparam logic [23:0] COL_FLOOR_B = 24'h73BF2E;
	localparam logic [23:0] COL_GROUND  = 24'hDED895;
	localparam logic [23:0] COL_PIPE    = 24'h558022;
	localparam logic [23:0] COL_BIRD    = 24'hF8C838;

	// pause dimming, per channel
	localparam logic [7:0] DIM_MASK = 8'hF0;

endpackage

// File: hdl/layer_if.sv
interface layer_if;

	// scenery bands, from band_classifier
	logic sky;
	logic hills;
	logic floor;
	logic ground;
	// second floor tone
	logic stripe_b;
	// display_on, one stage late
	logic vis;
	// sprites, from obstacle_detect
	logic bird;
	logic pipe;

	modport band_src (output sky, hills, floor, ground, stripe_b, vis);

	modport obst_src (output bird, pipe);

	modport comp_dst (input sky, hills, floor, ground, stripe_b, vis, bird, pipe);

endinterface

// File: hdl/scroll_offset.sv
module scroll_offset (
	input  logic                    FL_clk,
	input  logic                    rst,
	input  logic                    frame_tick,
	input  render_pkg::game_state_t game_state,
	output render_pkg::coord_t      offset
);
	import render_pkg::*;

	// frozen while paused or on the end screen
	logic hold;

	assign hold = (game_state == st_pause) || (game_state == st_over);

	// one step per frame
	// counts 0..DISPLAY_W inclusive, then back to 0
	always_ff @(posedge FL_clk or posedge rst) begin
		if (rst) begin
			offset <= '0;
		end else if (frame_tick && !hold) begin
			if (offset == coord_t'(DISPLAY_W)) begin
				offset <= '0;
			end else begin
				offset <= offset + 1'b1;
			end
		end
	end

endmodule

// File: hdl/band_classifier.sv
module band_classifier #(
	parameter int SCALE = 2
) (
	input  logic                    FL_clk,
	input  logic                    rst,
	input  logic                    display_on,
	input  render_pkg::game_state_t game_state,
	input  render_pkg::coord_t      x,
	input  render_pkg::coord_t      y,
	input  render_pkg::coord_t      offset,
	output render_pkg::game_state_t state_d,
	layer_if.band_src               bands
);
	import render_pkg::*;

	// band limits in rows, end values exclusive
	localparam int HILLS_END = HILLS_Y + HILLS_ROWS * SCALE;
	// floor overlaps the last two hill rows
	localparam int FLOOR_Y = HILLS_Y + HILLS_ROWS * SCALE - 2;
	localparam int FLOOR_END = FLOOR_Y + FLOOR_ROWS * SCALE;
	localparam int STRIPE_W = STRIPE_COLS * SCALE;

	// x + offset, max 639 + 640
	logic [10:0] sum_x;
	coord_t      wrap_x;
	coord_t      stripe_idx;

	// scrolled column, wrapped back into the screen
	always_comb begin
		sum_x = {1'b0, x} + {1'b0, offset};
		if (sum_x >= 11'(DISPLAY_W)) begin
			wrap_x = coord_t'(sum_x - 11'(DISPLAY_W));
		end else begin
			wrap_x = coord_t'(sum_x);
		end
		// odd stripe index picks tone b
		stripe_idx = wrap_x / coord_t'(STRIPE_W);
	end

	always_ff @(posedge FL_clk or posedge rst) begin
		if (rst) begin
			bands.sky <= 1'b0;
			bands.hills <= 1'b0;
			bands.floor <= 1'b0;
			bands.ground <= 1'b0;
			bands.stripe_b <= 1'b0;
			bands.vis <= 1'b0;
			state_d <= st_start;
		end else begin
			bands.sky <= (y <= HILLS_Y);
			bands.hills <= (y >= HILLS_Y) && (y < HILLS_END);
			bands.floor <= (y >= FLOOR_Y) && (y < FLOOR_END);
			// everything under the floor, on screen
			bands.ground <= (y >= FLOOR_END) && (y < DISPLAY_H);
			bands.stripe_b <= stripe_idx[0];
			bands.vis <= display_on;
			// keeps state aligned with the pixel
			state_d <= game_state;
		end
	end

endmodule

// File: hdl/obstacle_detect.sv
module obstacle_detect #(
	parameter int SCALE = 2,
	parameter int PIPE_GAP = 60,
	parameter int NUM_PIPES = 4,
	parameter int BIRD_W = 34,
	parameter int BIRD_H = 24
) (
	input  logic                                FL_clk,
	input  logic                                rst,
	input  render_pkg::coord_t                  x,
	input  render_pkg::coord_t                  y,
	input  render_pkg::coord_t                  bird_x,
	input  render_pkg::coord_t                  bird_y,
	input  render_pkg::coord_t [NUM_PIPES-1:0]  pipe_x,
	input  render_pkg::coord_t [NUM_PIPES-1:0]  pipe_y,
	layer_if.obst_src                           obst
);
	import render_pkg::*;

	// pipe body in pixels
	localparam int PIPE_W = PIPE_COLS * SCALE;
	localparam int PIPE_H = PIPE_ROWS * SCALE;

	logic bird_hit;
	logic pipe_hit;

	//////////////////////////////////////////////////
	// box tests
	//////////////////////////////////////////////////

	// signed 12 bit so the top part can reach above row 0
	always_comb begin : hit_tests
		logic signed [11:0] xs;
		logic signed [11:0] ys;
		logic signed [11:0] px;
		logic signed [11:0] py;
		logic in_col;
		logic in_btm;
		logic in_top;
		xs = {2'b00, x};
		ys = {2'b00, y};
		bird_hit = (x >= bird_x) && ({2'b00, x} < {2'b00, bird_x} + 12'(BIRD_W))
			&& (y >= bird_y) && ({2'b00, y} < {2'b00, bird_y} + 12'(BIRD_H));
		pipe_hit = 1'b0;
		for (int i = 0; i < NUM_PIPES; i++) begin
			px = {2'b00, pipe_x[i]};
			py = {2'b00, pipe_y[i]};
			in_col = (xs >= px) && (xs < px + PIPE_W);
			// bottom part below the gap
			in_btm = (ys >= py + PIPE_GAP) && (ys < py + PIPE_GAP + PIPE_H);
			// top part hanging above the gap
			in_top = (ys > py - PIPE_GAP - PIPE_H) && (ys < py - PIPE_GAP);
			pipe_hit = pipe_hit | (in_col && (in_btm || in_top));
		end
	end

	always_ff @(posedge FL_clk or posedge rst) begin
		if (rst) begin
			obst.bird <= 1'b0;
			obst.pipe <= 1'b0;
		end else begin
			obst.bird <= bird_hit;
			obst.pipe <= pipe_hit;
		end
	end

endmodule

// File: hdl/layer_compositor.sv
module layer_compositor (
	input  logic                    FL_clk,
	input  logic                    rst,
	input  render_pkg::game_state_t state_d,
	layer_if.comp_dst               layers,
	output render_pkg::rgb_t        rgb
);
	import render_pkg::*;

	rgb_t base;
	rgb_t shade;
	// pipe not hidden by floor or ground
	logic pipe_vis;
	logic state_ok;

	//////////////////////////////////////////////////
	// layer priority
	//////////////////////////////////////////////////

	always_comb begin
		pipe_vis = layers.pipe && !layers.floor && !layers.ground;
		state_ok = $onehot(state_d);
		// top layer first
		// no pipes on the start screen
		if (layers.bird) begin
			base.word = COL_BIRD;
		end else if (pipe_vis && (state_d != st_start)) begin
			base.word = COL_PIPE;
		end else if (layers.sky) begin
			base.word = COL_SKY;
		end else if (layers.hills) begin
			base.word = COL_HILLS;
		end else if (layers.floor) begin
			base.word = layers.stripe_b ? COL_FLOOR_B : COL_FLOOR_A;
		end else if (layers.ground) begin
			base.word = COL_GROUND;
		end else begin
			base.word = COL_NONE;
		end

		// pause dims each channel on its own
		shade = base;
		if (state_d == st_pause) begin
			shade.ch.r = (base.ch.r & DIM_MASK) >> 2;
			shade.ch.g = (base.ch.g & DIM_MASK) >> 2;
			shade.ch.b = (base.ch.b & DIM_MASK) >> 2;
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	// black in blanking or with a bad state
	always_ff @(posedge FL_clk or posedge rst) begin
		if (rst) begin
			rgb.word <= COL_NONE;
		end else if (!layers.vis || !state_ok) begin
			rgb.word <= COL_NONE;
		end else begin
			rgb <= shade;
		end
	end

endmodule

// File: hdl/flappy_renderer.sv
module flappy_renderer #(
	parameter int SCALE = 2,
	parameter int PIPE_GAP = 60,
	parameter int NUM_PIPES = 4,
	parameter int BIRD_W = 34,
	parameter int BIRD_H = 24
) (
	input  logic                               FL_clk,
	input  logic                               rst,
	input  logic                               display_on,
	input  logic                               frame_tick,
	input  render_pkg::game_state_t            game_state,
	input  render_pkg::coord_t                 x,
	input  render_pkg::coord_t                 y,
	input  render_pkg::coord_t                 bird_x,
	input  render_pkg::coord_t                 bird_y,
	input  render_pkg::coord_t [NUM_PIPES-1:0] pipe_x,
	input  render_pkg::coord_t [NUM_PIPES-1:0] pipe_y,
	output render_pkg::rgb_t                   rgb
);
	import render_pkg::*;

	// floor scroll position
	coord_t      offset;
	// state one stage late, lines up with the flags
	game_state_t state_d;

	// per-pixel flags between the stages
	layer_if lif0 ();

	scroll_offset so0 (
		.FL_clk     (FL_clk),
		.rst        (rst),
		.frame_tick (frame_tick),
		.game_state (game_state),
		.offset     (offset)
	);

	band_classifier #(
		.SCALE (SCALE)
	) bc0 (
		.FL_clk     (FL_clk),
		.rst        (rst),
		.display_on (display_on),
		.game_state (game_state),
		.x          (x),
		.y          (y),
		.offset     (offset),
		.state_d    (state_d),
		.bands      (lif0.band_src)
	);

	obstacle_detect #(
		.SCALE     (SCALE),
		.PIPE_GAP  (PIPE_GAP),
		.NUM_PIPES (NUM_PIPES),
		.BIRD_W    (BIRD_W),
		.BIRD_H    (BIRD_H)
	) od0 (
		.FL_clk (FL_clk),
		.rst    (rst),
		.x      (x),
		.y      (y),
		.bird_x (bird_x),
		.bird_y (bird_y),
		.pipe_x (pipe_x),
		.pipe_y (pipe_y),
		.obst   (lif0.obst_src)
	);

	layer_compositor lc0 (
		.FL_clk  (FL_clk),
		.rst     (rst),
		.state_d (state_d),
		.layers  (lif0.comp_dst),
		.rgb     (rgb)
	);

endmodule

// File: test/tb_clock.sv
module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic FL_clk,
	output logic rst
);

	// free running clock
	initial begin
		FL_clk = 1'b0;
		forever #(PERIOD / 2) FL_clk = ~FL_clk;
	end

	// reset held over the first edges, released just after an edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge FL_clk);
		#1;
		rst = 1'b0;
	end

endmodule

// File: test/tb_flappy_renderer.sv
module tb_flappy_renderer;
	import render_pkg::*;

	localparam int NUM_PIPES = 4;
	localparam int NUM_RECORDS = 31;
	// ticks disp state x y bird_x bird_y pipe_sel pipe_x pipe_y rgb
	localparam int FIELDS = 11;
	localparam int MEM_WORDS = NUM_RECORDS * FIELDS;
	localparam int DRIVE_DELAY = 1;
	// beyond the right edge so never hit
	localparam coord_t PARK = coord_t'(1000);

	logic                         FL_clk;
	logic                         rst;
	logic                         display_on;
	logic                         frame_tick;
	game_state_t                  game_state;
	coord_t                       x;
	coord_t                       y;
	coord_t                       bird_x;
	coord_t                       bird_y;
	coord_t [NUM_PIPES-1:0]       pipe_x;
	coord_t [NUM_PIPES-1:0]       pipe_y;
	rgb_t                         rgb;

	logic [23:0] stim_mem [0:MEM_WORDS-1];
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	tb_clock #(.PERIOD(20), .RESET_CYCLES(4)) clk0 (.FL_clk(FL_clk), .rst(rst));

	flappy_renderer #(
		.SCALE     (2),
		.PIPE_GAP  (60),
		.NUM_PIPES (NUM_PIPES),
		.BIRD_W    (34),
		.BIRD_H    (24)
	) dut0 (
		.FL_clk     (FL_clk),
		.rst        (rst),
		.display_on (display_on),
		.frame_tick (frame_tick),
		.game_state (game_state),
		.x          (x),
		.y          (y),
		.bird_x     (bird_x),
		.bird_y     (bird_y),
		.pipe_x     (pipe_x),
		.pipe_y     (pipe_y),
		.rgb        (rgb)
	);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// marks words the file never wrote
	function automatic logic [23:0] fill_word(input int addr);
		return 24'hF00000 | 24'(addr);
	endfunction

	task automatic check_rgb(input rgb_t expected, input rgb_t actual, input coord_t px,
		input coord_t py);
		checks++;
		if (actual.word !== expected.word) begin
			errors++;
			$display("ERR %0t: pixel (%0d,%0d) expected %h got %h", $time, px, py,
				expected.word, actual.word);
		end
	endtask

	// bird and all pipes off screen
	task automatic park_sprites();
		bird_x = PARK;
		bird_y = '0;
		for (int i = 0; i < NUM_PIPES; i++) begin
			pipe_x[i] = PARK;
			pipe_y[i] = '0;
		end
	endtask

	// called one step after an edge
	task automatic apply_record(input int r);
		int base;
		int sel;
		rgb_t expected;
		base = r * FIELDS;
		display_on = stim_mem[base + 1][0];
		game_state = game_state_t'(stim_mem[base + 2][3:0]);
		x = coord_t'(stim_mem[base + 3]);
		y = coord_t'(stim_mem[base + 4]);
		park_sprites();
		bird_x = coord_t'(stim_mem[base + 5]);
		bird_y = coord_t'(stim_mem[base + 6]);
		sel = int'(stim_mem[base + 7]);
		if (sel < NUM_PIPES) begin
			pipe_x[sel] = coord_t'(stim_mem[base + 8]);
			pipe_y[sel] = coord_t'(stim_mem[base + 9]);
		end
		expected.word = stim_mem[base + 10];
		// ticks see the record's state
		// each tick is one cycle high then one cycle low
		repeat (stim_mem[base]) begin
			frame_tick = 1'b1;
			@(posedge FL_clk);
			#DRIVE_DELAY;
			frame_tick = 1'b0;
			@(posedge FL_clk);
			#DRIVE_DELAY;
		end
		frame_tick = 1'b0;
		// sample edge then two pipeline edges
		@(posedge FL_clk);
		@(posedge FL_clk);
		@(posedge FL_clk);
		#DRIVE_DELAY;
		check_rgb(expected, rgb, x, y);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin : run_records
		int total_ticks;
		total_ticks = 0;
		display_on = 1'b0;
		frame_tick = 1'b0;
		game_state = st_start;
		x = '0;
		y = '0;
		park_sprites();
		for (int i = 0; i < MEM_WORDS; i++) begin
			stim_mem[i] = fill_word(i);
		end
		$readmemh("test/render_stimulus.txt", stim_mem);
		if (stim_mem[MEM_WORDS - 1] == fill_word(MEM_WORDS - 1)) begin
			$display("stimulus file is missing or holds fewer than %0d records",
				NUM_RECORDS);
			errors++;
		end else begin
			for (int r = 0; r < NUM_RECORDS; r++) begin
				total_ticks += int'(stim_mem[r * FIELDS]);
			end
			cycle_limit = 4 * (NUM_RECORDS + total_ticks) + 50;
			// black while in reset and right after it
			@(posedge FL_clk);
			#DRIVE_DELAY;
			check_rgb(rgb_t'(COL_NONE), rgb, x, y);
			@(negedge rst);
			check_rgb(rgb_t'(COL_NONE), rgb, x, y);
			for (int r = 0; r < NUM_RECORDS; r++) begin
				apply_record(r);
			end
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// run length guard
	always @(posedge FL_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

endmodule

// File: test/render_stimulus.txt
// ticks disp state x y bird_x bird_y pipe_sel pipe_x pipe_y expected_rgb, all hex
// pipes other than pipe_sel are parked off screen
000 0 1 064 064 3E8 000 0 3E8 000 000000
000 0 2 064 064 05A 05A 0 3E8 000 000000
000 0 4 064 064 3E8 000 0 3E8 000 000000
000 0 8 064 064 3E8 000 0 3E8 000 000000
000 1 1 064 064 3E8 000 0 3E8 000 70C5CE
000 1 1 064 140 3E8 000 0 3E8 000 5EC45A
000 1 1 064 1D6 3E8 000 0 3E8 000 DED895
000 1 1 064 064 05A 05A 0 3E8 000 F8C838
000 1 1 064 096 3E8 000 0 050 190 70C5CE
000 1 2 064 096 3E8 000 0 050 190 558022
000 1 2 064 0C8 3E8 000 0 050 064 558022
000 1 2 064 082 3E8 000 0 050 064 70C5CE
000 1 2 064 186 3E8 000 0 050 064 9BE15D
000 1 2 064 15E 3E8 000 0 050 064 558022
000 1 2 064 18E 3E8 000 0 050 064 DED895
000 1 2 064 0C8 05A 0BE 0 050 064 F8C838
000 1 2 0D2 12C 3E8 000 3 0C8 064 558022
000 1 2 064 064 3E8 000 0 050 190 70C5CE
000 1 2 000 181 3E8 000 0 3E8 000 9BE15D
000 1 2 010 181 3E8 000 0 3E8 000 73BF2E
005 1 2 00C 181 3E8 000 0 3E8 000 73BF2E
000 1 2 00A 181 3E8 000 0 3E8 000 9BE15D
014 1 4 00B 181 3E8 000 0 3E8 000 1C2C08
00A 1 8 00B 181 3E8 000 0 3E8 000 73BF2E
000 1 2 00B 181 3E8 000 0 3E8 000 73BF2E
27C 1 2 00F 181 3E8 000 0 3E8 000 9BE15D
001 1 2 00F 181 3E8 000 0 3E8 000 73BF2E
000 1 4 064 064 3E8 000 0 3E8 000 1C3030
000 1 4 064 064 05A 05A 0 3E8 000 3C300C
000 1 3 064 064 3E8 000 0 3E8 000 000000
000 1 0 064 064 3E8 000 0 3E8 000 000000

// File: flappy_renderer.f
hdl/render_pkg.sv
hdl/layer_if.sv
hdl/scroll_offset.sv
hdl/band_classifier.sv
hdl/obstacle_detect.sv
hdl/layer_compositor.sv
hdl/flappy_renderer.sv
test/tb_clock.sv
test/tb_flappy_renderer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the flappy_renderer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_flappy_renderer \
	-f flappy_renderer.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_flappy_renderer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1
